// File: Bender.yml
package:
  name: cr16_cpu

sources:
  - cpu_pkg.sv
  - alu.sv
  - regfile.sv
  - program_counter.sv
  - control_decoder.sv
  - dual_port_ram.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_cpu.sv

// File: alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  cpu_pkg::word_t   a,          // rdest value
	input  cpu_pkg::word_t   b,          // rsrc value or imm8
	input  cpu_pkg::opcode_t op,
	input  logic             cin,        // stored carry, used by ADDC
	output cpu_pkg::word_t   result,
	output cpu_pkg::flags_t  flags_next
);

	import cpu_pkg::*;

	logic        is_sub;   // SUB, SUBI and CMP share the subtract path
	logic        carry_in;
	word_t       b_eff;    // b or ~b into the adder
	logic [16:0] sum;      // carry in bit 16

	always_comb begin
		is_sub = (op == OP_SUB) || (op == OP_SUBI) || (op == OP_CMP);
		b_eff = is_sub ? ~b : b;
		if (is_sub) begin
			carry_in = 1'b1; // a + ~b + 1
		end else if (op == OP_ADDC) begin
			carry_in = cin;
		end else begin
			carry_in = 1'b0;
		end
		sum = {1'b0, a} + {1'b0, b_eff} + {16'd0, carry_in};
	end

	always_comb begin
		case (op)
			OP_ADD, OP_ADDI, OP_ADDC: result = sum[15:0];
			OP_SUB, OP_SUBI, OP_CMP:  result = sum[15:0]; // CMP result is not written
			OP_AND:                   result = a & b;
			OP_OR:                    result = a | b;
			OP_XOR:                   result = a ^ b;
			OP_MOV, OP_MOVI:          result = b;
			default:                  result = b; // load, store, branch, halt
		endcase
	end

	// all flags from the adder so CMP and SUB always agree
	always_comb begin
		flags_next         = '0;
		flags_next[FLAG_C] = sum[16];
		flags_next[FLAG_L] = is_sub & ~sum[16]; // borrow means a < b unsigned
		flags_next[FLAG_F] = (a[15] == b_eff[15]) & (sum[15] != a[15]);
		flags_next[FLAG_Z] = (sum[15:0] == '0);
		flags_next[FLAG_N] = sum[15];
	end

endmodule

`default_nettype wire

// File: control_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module control_decoder (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::word_t     instr,        // ram q_a
	input  cpu_pkg::flags_t    flags_next,   // from alu
	output logic               pc_en,
	output logic               branch_take,
	output logic               mem_sel_data, // 1: rsrc value on port a, 0: pc
	output logic               mem_we,
	output logic               imm_sel,      // alu b from imm8
	output logic               wb_sel,       // 1: write back q_a
	output logic               reg_we,
	output cpu_pkg::opcode_t   op,
	output cpu_pkg::reg_addr_t rdest,
	output cpu_pkg::reg_addr_t rsrc,
	output cpu_pkg::imm_t      imm8,
	output logic               carry,        // stored C for ADDC
	output logic               halted
);

	import cpu_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	word_t       ir;        // current instruction
	flags_t      flags_q;   // flag register
	logic        set_flags; // arith ops and CMP only

	// instruction fields
	assign op    = ir[15:12];
	assign rdest = ir[11:8];
	assign rsrc  = ir[3:0];
	assign imm8  = ir[7:0];

	assign imm_sel = (op == OP_ADDI) || (op == OP_SUBI) || (op == OP_MOVI);
	assign carry   = flags_q[FLAG_C];
	assign halted  = (state == S_HALT);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= S_FETCH;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ir <= '0;
		end else if (state == S_DECODE) begin
			ir <= instr; // q_a holds mem[pc] here
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			flags_q <= '0;
		end else if (set_flags) begin
			flags_q <= flags_next;
		end
	end

	always_comb begin
		state_next   = state;
		pc_en        = 1'b0;
		branch_take  = 1'b0;
		mem_sel_data = 1'b0;
		mem_we       = 1'b0;
		wb_sel       = 1'b0;
		reg_we       = 1'b0;
		set_flags    = 1'b0;
		case (state)
			S_FETCH:  state_next = S_DECODE; // port a reads pc
			S_DECODE: state_next = S_EXEC;
			S_EXEC: begin
				state_next = S_FETCH; // 3-cycle ops by default
				case (op)
					OP_ADD, OP_ADDI, OP_ADDC, OP_SUB, OP_SUBI: begin
						reg_we    = 1'b1;
						set_flags = 1'b1;
						pc_en     = 1'b1;
					end
					OP_CMP: begin
						set_flags = 1'b1; // no writeback
						pc_en     = 1'b1;
					end
					OP_AND, OP_OR, OP_XOR, OP_MOV, OP_MOVI: begin
						reg_we = 1'b1;
						pc_en  = 1'b1;
					end
					OP_LOAD: begin
						mem_sel_data = 1'b1; // q_a valid in S_MEM
						state_next   = S_MEM;
					end
					OP_STORE: begin
						mem_sel_data = 1'b1;
						mem_we       = 1'b1; // write on this edge
						state_next   = S_MEM;
					end
					OP_BEQ: begin
						pc_en       = 1'b1;
						branch_take = flags_q[FLAG_Z];
					end
					OP_BNE: begin
						pc_en       = 1'b1;
						branch_take = ~flags_q[FLAG_Z];
					end
					OP_HALT: state_next = S_HALT; // pc stays on the halt
					default: state_next = S_HALT; // unknown opcode parks the core
				endcase
			end
			S_MEM: begin
				pc_en      = 1'b1;
				state_next = S_FETCH;
				if (op == OP_LOAD) begin
					reg_we = 1'b1;
					wb_sel = 1'b1; // rdest <= q_a
				end
			end
			S_HALT:  state_next = S_HALT;
			default: state_next = S_FETCH;
		endcase
	end

	a_one_writer: assert property (@(posedge clk) disable iff (!reset)
		!(reg_we && mem_we))
		else $error("register and memory write in the same cycle");

	a_halt_sticks: assert property (@(posedge clk) disable iff (!reset)
		(state == S_HALT) |=> (state == S_HALT))
		else $error("FSM left S_HALT without reset");

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// datapath widths
	localparam int WORD_W     = 16;
	localparam int REG_ADDR_W = 4;
	localparam int IMM_W      = 8;
	localparam int NUM_REGS   = 16; // r0 is a normal register
	localparam int FLAGS_W    = 5;

	// shared memory for code and data
	localparam int RAM_DEPTH  = 256;
	localparam int RAM_ADDR_W = 8;

	typedef logic [WORD_W-1:0]     word_t;     // data, address or instruction
	typedef logic [REG_ADDR_W-1:0] reg_addr_t; // register index
	typedef logic [IMM_W-1:0]      imm_t;      // immediate or branch disp
	typedef logic [3:0]            opcode_t;   // instr[15:12]
	typedef logic [FLAGS_W-1:0]    flags_t;

	// opcodes
	localparam opcode_t OP_ADD   = 4'h0;
	localparam opcode_t OP_ADDI  = 4'h1; // zero-extended imm8
	localparam opcode_t OP_ADDC  = 4'h2; // adds the stored carry
	localparam opcode_t OP_SUB   = 4'h3;
	localparam opcode_t OP_SUBI  = 4'h4;
	localparam opcode_t OP_CMP   = 4'h5; // flags only
	localparam opcode_t OP_AND   = 4'h6;
	localparam opcode_t OP_OR    = 4'h7;
	localparam opcode_t OP_XOR   = 4'h8;
	localparam opcode_t OP_MOV   = 4'h9;
	localparam opcode_t OP_MOVI  = 4'ha;
	localparam opcode_t OP_LOAD  = 4'hb; // rdest <= mem[rsrc]
	localparam opcode_t OP_STORE = 4'hc; // mem[rsrc] <= rdest
	localparam opcode_t OP_BEQ   = 4'hd; // signed disp in imm8
	localparam opcode_t OP_BNE   = 4'he;
	localparam opcode_t OP_HALT  = 4'hf;

	// bit positions in flags_t
	localparam int FLAG_C = 0; // carry out
	localparam int FLAG_L = 1; // unsigned less-than
	localparam int FLAG_F = 2; // signed overflow
	localparam int FLAG_Z = 3; // zero
	localparam int FLAG_N = 4; // negative

	// multicycle control sequence
	typedef enum logic [2:0] {
		S_FETCH,  // pc on ram port a
		S_DECODE, // ir loads q_a
		S_EXEC,   // alu, branch, or address phase of load/store
		S_MEM,    // load writeback, store done
		S_HALT    // parked until reset
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           load_we,   // loader port = ram port b
	input  logic [cpu_pkg::RAM_ADDR_W-1:0] load_addr,
	input  cpu_pkg::word_t                 load_data,
	output cpu_pkg::word_t                 alu_out,
	output logic                           halted,
	output cpu_pkg::word_t                 load_q     // one cycle after load_addr
);

	import cpu_pkg::*;

	// control
	logic      pc_en;
	logic      branch_take;
	logic      mem_sel_data;
	logic      mem_we;
	logic      imm_sel;
	logic      wb_sel;
	logic      reg_we;
	logic      carry;
	opcode_t   op;
	reg_addr_t rdest;
	reg_addr_t rsrc;
	imm_t      imm8;
	flags_t    flags_next;

	// datapath
	word_t pc;
	word_t q_a;
	word_t rdata_a;  // rdest value, store data
	word_t rdata_b;  // rsrc value, load/store address
	word_t mem_addr; // full width before truncation
	word_t alu_b;
	word_t wb_data;

	assign mem_addr = mem_sel_data ? rdata_b : pc;
	assign alu_b    = imm_sel ? {8'h00, imm8} : rdata_b; // imm zero-extended
	assign wb_data  = wb_sel ? q_a : alu_out;

	dual_port_ram ram0 (
		.clk    (clk),
		.we_a   (mem_we),
		.addr_a (mem_addr[RAM_ADDR_W-1:0]), // 256 words, upper bits dropped
		.data_a (rdata_a),
		.we_b   (load_we),
		.addr_b (load_addr),
		.data_b (load_data),
		.q_a    (q_a),
		.q_b    (load_q)
	);

	program_counter pc0 (
		.clk         (clk),
		.reset       (reset),
		.en          (pc_en),
		.branch_take (branch_take),
		.disp        (imm8),
		.pc          (pc)
	);

	control_decoder ctrl0 (
		.clk          (clk),
		.reset        (reset),
		.instr        (q_a),
		.flags_next   (flags_next),
		.pc_en        (pc_en),
		.branch_take  (branch_take),
		.mem_sel_data (mem_sel_data),
		.mem_we       (mem_we),
		.imm_sel      (imm_sel),
		.wb_sel       (wb_sel),
		.reg_we       (reg_we),
		.op           (op),
		.rdest        (rdest),
		.rsrc         (rsrc),
		.imm8         (imm8),
		.carry        (carry),
		.halted       (halted)
	);

	regfile regs0 (
		.clk     (clk),
		.reset   (reset),
		.we      (reg_we),
		.waddr   (rdest),
		.wdata   (wb_data),
		.raddr_a (rdest),
		.raddr_b (rsrc),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	alu alu0 (
		.a          (rdata_a),
		.b          (alu_b),
		.op         (op),
		.cin        (carry),
		.result     (alu_out),
		.flags_next (flags_next)
	);

endmodule

`default_nettype wire

// File: dual_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram (
	input  logic                            clk,
	input  logic                            we_a,   // core side
	input  logic [cpu_pkg::RAM_ADDR_W-1:0]  addr_a,
	input  cpu_pkg::word_t                  data_a,
	input  logic                            we_b,   // loader side
	input  logic [cpu_pkg::RAM_ADDR_W-1:0]  addr_b,
	input  cpu_pkg::word_t                  data_b,
	output cpu_pkg::word_t                  q_a,
	output cpu_pkg::word_t                  q_b
);

	import cpu_pkg::*;

	word_t mem [RAM_DEPTH];

	// both ports read-first, q shows the old word on a write
	always_ff @(posedge clk) begin
		if (we_a) begin
			mem[addr_a] <= data_a;
		end
		if (we_b) begin
			mem[addr_b] <= data_b; // b wins a collision
		end
		q_a <= mem[addr_a];
		q_b <= mem[addr_b];
	end

	a_no_collision: assert property (@(posedge clk)
		!(we_a && we_b && (addr_a == addr_b)))
		else $error("both ports write address %0d", addr_a);

endmodule

`default_nettype wire

// File: filelist.f
cpu_pkg.sv
alu.sv
regfile.sv
program_counter.sv
control_decoder.sv
dual_port_ram.sv
cpu_top.sv
tb_cpu.sv

// File: program_counter.sv
`timescale 1ns/100ps
`default_nettype none

module program_counter (
	input  logic           clk,
	input  logic           reset,
	input  logic           en,          // last cycle of an instruction
	input  logic           branch_take,
	input  cpu_pkg::imm_t  disp,        // signed word offset
	output cpu_pkg::word_t pc
);

	import cpu_pkg::*;

	word_t offset;

	// sign-extend disp only when the branch is taken
	assign offset = branch_take ? {{8{disp[7]}}, disp} : '0;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0; // programs start at 0
		end else if (en) begin
			pc <= pc + 16'd1 + offset; // pc + 1 + disp
		end
	end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
	input  logic               clk,
	input  logic               reset,
	input  logic               we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::word_t     wdata,
	input  cpu_pkg::reg_addr_t raddr_a, // rdest
	input  cpu_pkg::reg_addr_t raddr_b, // rsrc
	output cpu_pkg::word_t     rdata_a,
	output cpu_pkg::word_t     rdata_b
);

	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// async reads, new value visible the cycle after the write
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	a_waddr_known: assert property (@(posedge clk) disable iff (!reset)
		we |-> !$isunknown(waddr))
		else $error("regfile write with unknown address");

endmodule

`default_nettype wire

// File: tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;

	import cpu_pkg::*;

	logic                  clk;
	logic                  reset;
	logic                  load_we;
	logic [RAM_ADDR_W-1:0] load_addr;
	word_t                 load_data;
	word_t                 alu_out;
	logic                  halted;
	word_t                 load_q;

	word_t       img [RAM_DEPTH];     // image sent through the loader
	word_t       mmem [RAM_DEPTH];    // model memory
	word_t       mreg [NUM_REGS];     // model registers
	word_t       dut_mem [RAM_DEPTH]; // last readback
	int          exec_cycle [$];      // run cycle of each alu execute state
	word_t       exec_result [$];     // alu_out expected in that cycle
	int          asm_pc;
	logic [31:0] seed;
	int          errors;
	int          n_checks;
	int          cycle_limit;         // 4 per executed instruction
	int          run_cycles;

	cpu_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.alu_out   (alu_out),
		.halted    (halted),
		.load_q    (load_q)
	);

	always #50 clk = ~clk;

	// watchdog, only cycles where the core runs
	always @(posedge clk) begin
		if (reset && !halted) begin
			run_cycles++;
			if (run_cycles > cycle_limit + 100) begin
				$display("timeout: core still running after %0d cycles", run_cycles);
				$display("checks: %0d, errors: %0d", n_checks, errors + 1);
				$display("Errors found");
				$finish;
			end
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t next_rand();
		seed = xorshift(seed);
		return seed[15:0];
	endfunction

	function automatic word_t enc(input opcode_t op, input logic [3:0] rd, input imm_t imm);
		return {op, rd, imm}; // rsrc form puts the index in imm[3:0]
	endfunction

	function automatic word_t fill_word(input int addr);
		logic [7:0] a;
		a = addr[7:0];
		return {a ^ 8'ha5, a}; // every address bit shows up
	endfunction

	task automatic check_value(input word_t got, input word_t exp, input string msg);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic emit(input word_t w);
		img[asm_pc] = w;
		asm_pc++;
	endtask

	task automatic fill_image();
		for (int i = 0; i < RAM_DEPTH; i++) begin
			img[i] = fill_word(i);
		end
		asm_pc = 0; // code from address 0
	endtask

	// reference model, plain instruction rules
	task automatic model_exec(output int steps);
		word_t      ir;
		word_t      a;
		word_t      b;
		word_t      pc_m;
		word_t      pc_next;
		logic [16:0] s;
		logic       c_m;
		logic       z_m;
		logic       done;
		opcode_t    op;
		logic [3:0] rd;
		int         t;          // cycles since reset release
		for (int i = 0; i < RAM_DEPTH; i++) mmem[i] = img[i];
		for (int i = 0; i < NUM_REGS; i++) mreg[i] = '0;
		exec_cycle.delete();
		exec_result.delete();
		pc_m = '0;
		c_m = 1'b0;
		z_m = 1'b0;
		done = 1'b0;
		steps = 0;
		t = 0;
		while (!done && steps < 1000) begin
			ir = mmem[pc_m[7:0]];
			steps++;
			op = ir[15:12];
			rd = ir[11:8];
			a = mreg[rd];
			b = (op == OP_ADDI || op == OP_SUBI || op == OP_MOVI) ?
				{8'h00, ir[7:0]} : mreg[ir[3:0]];
			pc_next = pc_m + 16'd1;
			case (op)
				OP_ADD, OP_ADDI, OP_ADDC: begin
					s = {1'b0, a} + {1'b0, b} + {16'd0, (op == OP_ADDC) & c_m};
					mreg[rd] = s[15:0];
				end
				OP_SUB, OP_SUBI, OP_CMP: begin
					s = {1'b0, a} + {1'b0, ~b} + 17'd1; // carry out of a + ~b + 1
					if (op != OP_CMP) mreg[rd] = s[15:0];
				end
				OP_AND:  mreg[rd] = a & b;
				OP_OR:   mreg[rd] = a | b;
				OP_XOR:  mreg[rd] = a ^ b;
				OP_MOV, OP_MOVI: mreg[rd] = b;
				OP_LOAD:  mreg[rd] = mmem[b[7:0]];
				OP_STORE: mmem[b[7:0]] = a;
				OP_BEQ: if (z_m) pc_next = pc_m + 16'd1 + {{8{ir[7]}}, ir[7:0]};
				OP_BNE: if (!z_m) pc_next = pc_m + 16'd1 + {{8{ir[7]}}, ir[7:0]};
				default: done = 1'b1; // halt
			endcase
			if (op <= OP_CMP) begin
				c_m = s[16];
				z_m = (s[15:0] == 16'd0);
			end
			if (op <= OP_MOVI && op != OP_CMP) begin
				exec_cycle.push_back(t + 2); // after fetch and decode
				exec_result.push_back(mreg[rd]);
			end
			t += (op == OP_LOAD || op == OP_STORE) ? 4 : 3;
			if (!done) pc_m = pc_next;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#10 reset = 1'b0;
		repeat (3) @(posedge clk);
		#10;
	endtask

	// whole image in while reset is low
	task automatic load_program();
		for (int i = 0; i < RAM_DEPTH; i++) begin
			@(posedge clk);
			#10;
			load_we = 1'b1;
			load_addr = i[7:0];
			load_data = img[i];
		end
		@(posedge clk);
		#10 load_we = 1'b0;
	endtask

	task automatic run();
		int steps;
		int cyc; // cycles since reset release
		int nxt; // next expected alu result
		model_exec(steps);
		cycle_limit += 4 * steps;
		cyc = 0;
		nxt = 0;
		@(posedge clk);
		#10 reset = 1'b1;
		do begin
			@(posedge clk);
			#10;
			cyc++;
			if (nxt < exec_cycle.size() && exec_cycle[nxt] == cyc) begin
				check_value(alu_out, exec_result[nxt], $sformatf("alu_out in cycle %0d", cyc));
				nxt++;
			end
		end while (!halted);
		if (nxt != exec_cycle.size()) begin
			errors++;
			$display("core halted with %0d ALU results not seen", exec_cycle.size() - nxt);
		end
	endtask

	// called 10 ns after an edge, q one cycle later
	task automatic read_mem(input logic [7:0] addr, output word_t q);
		load_addr = addr;
		@(posedge clk);
		#10 q = load_q;
	endtask

	task automatic compare_memory();
		for (int i = 0; i < RAM_DEPTH; i++) begin
			read_mem(i[7:0], dut_mem[i]);
			check_value(dut_mem[i], mmem[i], $sformatf("mem[%02h]", i));
		end
	endtask

	task automatic alu_ops();
		word_t   a;
		word_t   b;
		word_t   k;
		opcode_t ops [5];
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
		a = next_rand() & 16'h00ff;
		b = next_rand() & 16'h00ff;
		k = next_rand() & 16'h00ff;
		apply_reset();
		fill_image();
		emit(enc(OP_MOVI, 1, a[7:0]));
		emit(enc(OP_MOVI, 2, b[7:0]));
		emit(enc(OP_MOVI, 15, 8'h80)); // store pointer
		for (int i = 0; i < 5; i++) begin
			emit(enc(OP_MOV, 3, 8'h01));
			emit(enc(ops[i], 3, 8'h02));
			emit(enc(OP_STORE, 3, 8'h0f));
			emit(enc(OP_ADDI, 15, 8'h01));
		end
		emit(enc(OP_ADDI, 1, k[7:0]));
		emit(enc(OP_STORE, 1, 8'h0f));
		emit(enc(OP_HALT, 0, 8'h00));
		load_program();
		run();
		compare_memory();
		check_value(dut_mem[8'h80], a + b, "ADD result");
		check_value(dut_mem[8'h81], a - b, "SUB result");
		check_value(dut_mem[8'h85], a + k, "ADDI result");
	endtask

	task automatic carry_and_compare();
		word_t       v [4];  // a_lo a_hi b_lo b_hi
		word_t       x;
		logic [31:0] sum32;
		v[0] = next_rand() | 16'h8000; // low halves overflow
		v[1] = next_rand();
		v[2] = next_rand() | 16'h8000;
		v[3] = next_rand();
		x = next_rand() & 16'h00ff;
		sum32 = {v[1], v[0]} + {v[3], v[2]};
		apply_reset();
		fill_image();
		for (int i = 0; i < 4; i++) img[8'h90 + i] = v[i];
		emit(enc(OP_MOVI, 15, 8'h90));
		for (int i = 1; i <= 4; i++) begin
			emit(enc(OP_LOAD, i[3:0], 8'h0f));
			if (i < 4) emit(enc(OP_ADDI, 15, 8'h01));
		end
		emit(enc(OP_ADD, 1, 8'h03)); // sets C
		emit(enc(OP_ADDC, 2, 8'h04));
		emit(enc(OP_MOVI, 15, 8'ha0));
		emit(enc(OP_STORE, 1, 8'h0f));
		emit(enc(OP_MOVI, 15, 8'ha1));
		emit(enc(OP_STORE, 2, 8'h0f));
		emit(enc(OP_MOVI, 5, x[7:0]));
		emit(enc(OP_MOVI, 6, x[7:0]));
		emit(enc(OP_MOVI, 15, 8'ha2));
		emit(enc(OP_CMP, 5, 8'h06));
		emit(enc(OP_BEQ, 0, 8'h01)); // over the next store
		emit(enc(OP_STORE, 5, 8'h0f));
		emit(enc(OP_MOVI, 14, 8'ha3));
		emit(enc(OP_STORE, 6, 8'h0e));
		emit(enc(OP_HALT, 0, 8'h00));
		load_program();
		run();
		compare_memory();
		check_value(dut_mem[8'ha0], sum32[15:0], "32-bit sum low");
		check_value(dut_mem[8'ha1], sum32[31:16], "32-bit sum high");
		check_value(dut_mem[8'ha2], fill_word(8'ha2), "store after BEQ skipped");
		check_value(dut_mem[8'ha3], x, "code after BEQ target");
	endtask

	task automatic countdown_loop();
		int    n;
		int    lp;
		int    d;
		word_t r;
		r = next_rand();
		n = 1 + (r % 10);
		apply_reset();
		fill_image();
		emit(enc(OP_MOVI, 1, n[7:0])); // counter
		emit(enc(OP_MOVI, 2, 8'h00));  // total
		lp = asm_pc;
		emit(enc(OP_ADDI, 2, 8'h03));
		emit(enc(OP_SUBI, 1, 8'h01));
		d = lp - asm_pc - 1; // target = pc + 1 + disp
		emit(enc(OP_BNE, 0, d[7:0]));
		emit(enc(OP_MOVI, 15, 8'hb0));
		emit(enc(OP_STORE, 1, 8'h0f));
		emit(enc(OP_ADDI, 15, 8'h01));
		emit(enc(OP_STORE, 2, 8'h0f));
		emit(enc(OP_HALT, 0, 8'h00));
		load_program();
		run();
		compare_memory();
		check_value(dut_mem[8'hb0], 16'd0, "loop counter");
		check_value(dut_mem[8'hb1], 3 * n, "loop total");
	endtask

	task automatic load_increment_store();
		word_t v [4];
		apply_reset();
		fill_image();
		for (int i = 0; i < 4; i++) begin
			v[i] = next_rand();
			img[8'hc0 + i] = v[i];
		end
		emit(enc(OP_MOVI, 15, 8'hc0));
		for (int i = 0; i < 4; i++) begin
			emit(enc(OP_LOAD, 1, 8'h0f));
			emit(enc(OP_ADDI, 1, 8'h01));
			emit(enc(OP_STORE, 1, 8'h0f));
			emit(enc(OP_ADDI, 15, 8'h01));
		end
		emit(enc(OP_HALT, 0, 8'h00));
		load_program();
		run();
		compare_memory();
		for (int i = 0; i < 4; i++) begin
			check_value(dut_mem[8'hc0 + i], v[i] + 16'd1, $sformatf("incremented word %0d", i));
		end
	endtask

	task automatic halt_then_reset();
		apply_reset();
		fill_image();
		emit(enc(OP_MOVI, 1, 8'h55));
		emit(enc(OP_MOVI, 15, 8'hd0));
		emit(enc(OP_STORE, 1, 8'h0f));
		emit(enc(OP_HALT, 0, 8'h00));
		load_program();
		run();
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			#10 check_value({15'd0, halted}, 16'd1, "halted held");
		end
		compare_memory(); // nothing written past the halt
		apply_reset();
		check_value({15'd0, halted}, 16'd0, "halted cleared by reset");
		fill_image();
		emit(enc(OP_MOVI, 2, 8'h77));
		emit(enc(OP_MOVI, 14, 8'hd1));
		emit(enc(OP_STORE, 2, 8'h0e));
		emit(enc(OP_HALT, 0, 8'h00));
		load_program();
		run();
		compare_memory();
		check_value(dut_mem[8'hd1], 16'h0077, "second program from address 0");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		seed = 32'h1923;
		errors = 0;
		n_checks = 0;
		cycle_limit = 0;
		run_cycles = 0;
		alu_ops();
		carry_and_compare();
		countdown_loop();
		load_increment_store();
		halt_then_reset();
		$display("checks: %0d, errors: %0d", n_checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
